//--- build.f
hdl/rxq_cfg_pkg.sv
hdl/rxq_reg_pkg.sv
hdl/rxq_if.sv
hdl/sync_fifo.sv
hdl/read_queue.sv
hdl/byte_packer.sv
hdl/rxq_csr_ctrl.sv
hdl/rxq_top.sv
tb/rxq_checker.sv
tb/rxq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rxq_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/rxq_tb.sv
// Every wait is bounded by STEP_TMO cycles; RX_DATA expectations come from a byte packing model
`timescale 1ns/1ps
`default_nettype none

module rxq_tb import rxq_cfg_pkg::*; import rxq_reg_pkg::*; ();

  localparam int STEP_TMO = 200;
  localparam int POLL_MAX = 20;

  typedef enum logic [2:0] {
    S_SEND, S_WR, S_RD, S_RDQ, S_IRQ, S_RDY, S_POLL, S_END
  } step_op_e;

  // a, b, c meaning depends on op
  typedef struct packed {
    step_op_e    op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } step_t;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              wb_cyc, wb_stb, wb_we;
  logic [ADR_W-1:0]  wb_adr;
  logic [DATA_W-1:0] wb_dat_w, wb_dat_r;
  logic              wb_ack;
  logic              rx_valid, rx_last, rx_ready;
  logic [7:0]        rx_data;
  logic              irq;

  // Checker strobes
  logic              rd_chk, lvl_chk, lvl_sel, exp_lvl, test_end, report;
  logic [DATA_W-1:0] exp_dat, exp_mask;
  logic [7:0]        test_num;
  int                err_cnt;

  step_t             steps[$];
  logic [DATA_W-1:0] model_q[$];
  logic [DATA_W-1:0] part_word;
  int                part_idx;
  integer            seed;
  bit                timed_out;

  rxq_top rxq_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_last_i  (rx_last),
    .rx_ready_o (rx_ready),
    .irq_o      (irq)
  );

  rxq_checker rxq_checker_inst (
    .clk_i      (clk_i),
    .wb_ack_i   (wb_ack),
    .wb_dat_i   (wb_dat_r),
    .irq_i      (irq),
    .rx_ready_i (rx_ready),
    .rd_chk_i   (rd_chk),
    .exp_dat_i  (exp_dat),
    .exp_mask_i (exp_mask),
    .lvl_chk_i  (lvl_chk),
    .lvl_sel_i  (lvl_sel),
    .exp_lvl_i  (exp_lvl),
    .test_end_i (test_end),
    .test_num_i (test_num),
    .report_i   (report),
    .err_cnt_o  (err_cnt)
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  function automatic void add_step(step_op_e op, logic [31:0] a, logic [31:0] b,
                                   logic [31:0] c);
    step_t s;
    s.op = op;
    s.a  = a;
    s.b  = b;
    s.c  = c;
    steps.push_back(s);
  endfunction

  // Little-endian packing with the word closed on the fourth or last byte
  function automatic void pack_byte(logic [7:0] b, logic last);
    part_word[8*part_idx +: 8] = b;
    if (last || part_idx == 3) begin
      model_q.push_back(part_word);
      part_word = '0;
      part_idx = 0;
    end else begin
      part_idx = part_idx + 1;
    end
  endfunction

  // One Wishbone classic access; cyc and stb are held through the ack edge
  task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    int waited;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    @(negedge clk_i);
    waited = 1;
    while (!wb_ack && waited < STEP_TMO) begin
      @(negedge clk_i);
      waited = waited + 1;
    end
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack for address %h", adr);
      timed_out = 1'b1;
    end
    rdat = wb_dat_r;
    @(negedge clk_i);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    rd_chk = 1'b0;
  endtask

  task automatic send_bytes(input int n, input logic last);
    int         waited;
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = 8'($random(seed));
      rx_valid = 1'b1;
      rx_data = b;
      rx_last = last && (i == n - 1);
      waited = 0;
      while (!rx_ready && waited < STEP_TMO) begin
        @(negedge clk_i);
        waited = waited + 1;
      end
      if (!rx_ready) begin
        $display("Timeout: rx_ready_o stayed low at byte %0d", i);
        timed_out = 1'b1;
        break;
      end
      @(negedge clk_i);
      pack_byte(b, rx_last);
    end
    rx_valid = 1'b0;
    rx_last = 1'b0;
    rx_data = '0;
    // Let the last word reach the queue
    repeat (2) @(negedge clk_i);
  endtask

  task automatic check_level(input logic sel, input logic exp);
    lvl_sel = sel;
    exp_lvl = exp;
    lvl_chk = 1'b1;
    @(negedge clk_i);
    lvl_chk = 1'b0;
  endtask

  task automatic poll_until_clear(input logic [ADR_W-1:0] adr, input logic [31:0] mask);
    int                polls;
    logic [DATA_W-1:0] r;
    polls = 0;
    r = mask;
    while ((r & mask) != '0 && polls < POLL_MAX && !timed_out) begin
      bus_access(1'b0, adr, '0, r);
      polls = polls + 1;
    end
    if ((r & mask) != '0) begin
      $display("Timeout: register %h did not clear after %0d polls", adr, polls);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    step_t             st;
    logic [DATA_W-1:0] rdat;
    rst_ni = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    rx_valid = 1'b0;
    rx_data = '0;
    rx_last = 1'b0;
    rd_chk = 1'b0;
    lvl_chk = 1'b0;
    lvl_sel = 1'b0;
    exp_lvl = 1'b0;
    exp_dat = '0;
    exp_mask = '0;
    test_end = 1'b0;
    test_num = '0;
    report = 1'b0;
    part_word = '0;
    part_idx = 0;
    seed = 24233;
    timed_out = 1'b0;

    // Reset values
    add_step(S_RD, 32'(STATUS), 32'h1, 32'hF);
    add_step(S_RD, 32'(THLD), 32'h0, 32'h1F1F);
    add_step(S_IRQ, 0, 0, 0);
    add_step(S_END, 1, 0, 0);
    // Short packet with a partly filled second word
    add_step(S_SEND, 6, 1, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RD, 32'(STATUS), 32'h1, 32'h1);
    add_step(S_END, 2, 0, 0);
    // Ready 4, start 13
    add_step(S_WR, 32'(THLD), 32'h040D, 0);
    add_step(S_SEND, 16, 0, 0);
    add_step(S_RD, 32'(STATUS), 32'h8, 32'hF);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_RDQ, 0, 0, 0);
    add_step(S_SEND, 12, 0, 0);
    add_step(S_RD, 32'(STATUS), 32'h4, 32'hF);
    add_step(S_WR, 32'(IRQ_EN), 32'h1, 0);
    add_step(S_IRQ, 1, 0, 0);
    add_step(S_WR, 32'(IRQ_EN), 32'h2, 0);
    add_step(S_IRQ, 0, 0, 0);
    add_step(S_SEND, 4, 0, 0);
    add_step(S_IRQ, 1, 0, 0);
    for (int i = 0; i < 4; i++) add_step(S_RDQ, 0, 0, 0);
    add_step(S_WR, 32'(IRQ_EN), 32'h0, 0);
    add_step(S_IRQ, 0, 0, 0);
    add_step(S_END, 3, 0, 0);
    // Ready threshold 20 clamps to 15
    add_step(S_WR, 32'(THLD), 32'h1400, 0);
    add_step(S_RD, 32'(THLD), 32'h0F00, 32'h1F1F);
    add_step(S_WR, 32'(THLD), 32'h0, 0);
    add_step(S_END, 4, 0, 0);
    // Overfill by one word
    add_step(S_SEND, 68, 0, 0);
    add_step(S_RDY, 0, 0, 0);
    add_step(S_RD, 32'(STATUS), 32'h2, 32'h3);
    for (int i = 0; i < 17; i++) add_step(S_RDQ, 0, 0, 0);
    add_step(S_RD, 32'(STATUS), 32'h1, 32'h3);
    add_step(S_END, 5, 0, 0);
    // Queue reset with words pending
    add_step(S_SEND, 12, 0, 0);
    add_step(S_WR, 32'(CTRL), 32'h1, 0);
    add_step(S_POLL, 32'(CTRL), 32'h1, 0);
    add_step(S_RD, 32'(STATUS), 32'h1, 32'h1);
    add_step(S_END, 6, 0, 0);

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int k = 0; k < steps.size(); k++) begin
      st = steps[k];
      case (st.op)
        S_SEND: send_bytes(int'(st.a), st.b[0]);
        S_WR: begin
          bus_access(1'b1, ADR_W'(st.a), st.b, rdat);
          if (st.a == 32'(CTRL) && st.b[CTRL_QRST]) begin
            model_q.delete();
          end
        end
        S_RD: begin
          exp_dat = st.b;
          exp_mask = st.c;
          rd_chk = 1'b1;
          bus_access(1'b0, ADR_W'(st.a), '0, rdat);
        end
        S_RDQ: begin
          // Empty queue reads as zero
          exp_dat = '0;
          if (model_q.size() > 0) begin
            exp_dat = model_q.pop_front();
          end
          exp_mask = '1;
          rd_chk = 1'b1;
          bus_access(1'b0, ADR_W'(RX_DATA), '0, rdat);
        end
        S_IRQ: check_level(1'b0, st.a[0]);
        S_RDY: check_level(1'b1, st.a[0]);
        S_POLL: poll_until_clear(ADR_W'(st.a), st.b);
        S_END: begin
          test_num = st.a[7:0];
          test_end = 1'b1;
          @(negedge clk_i);
          test_end = 1'b0;
        end
        default: ;
      endcase
      if (timed_out) break;
    end

    report = 1'b1;
    @(negedge clk_i);
    report = 1'b0;
    @(negedge clk_i);
    if (timed_out || err_cnt != 0) begin
      $display("*** TEST FAILED ***");
    end else begin
      $display("*** TEST PASSED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/rxq_checker.sv
// Compares at the rising clock edge; the testbench strobes select which comparison applies
`timescale 1ns/1ps
`default_nettype none

module rxq_checker import rxq_cfg_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              wb_ack_i,
  input  wire logic [DATA_W-1:0] wb_dat_i,
  input  wire logic              irq_i,
  input  wire logic              rx_ready_i,
  input  wire logic              rd_chk_i,
  input  wire logic [DATA_W-1:0] exp_dat_i,
  input  wire logic [DATA_W-1:0] exp_mask_i,
  input  wire logic              lvl_chk_i,
  input  wire logic              lvl_sel_i,
  input  wire logic              exp_lvl_i,
  input  wire logic              test_end_i,
  input  wire logic [7:0]        test_num_i,
  input  wire logic              report_i,
  output int                     err_cnt_o
);

  int   checks = 0;
  int   errors = 0;
  int   tests = 0;
  int   test_checks = 0;
  int   test_errors = 0;
  logic lvl_now;

  assign err_cnt_o = errors;

  always @(posedge clk_i) begin
    // Read data is valid on the single ack cycle
    if (rd_chk_i && wb_ack_i) begin
      checks = checks + 1;
      test_checks = test_checks + 1;
      if ((wb_dat_i & exp_mask_i) !== (exp_dat_i & exp_mask_i)) begin
        errors = errors + 1;
        test_errors = test_errors + 1;
        $display("Fail at %0t: wb_dat_o expected %h, got %h (mask %h)",
                 $time, exp_dat_i, wb_dat_i, exp_mask_i);
      end
    end
    // Level check on irq_o or rx_ready_o
    if (lvl_chk_i) begin
      lvl_now = lvl_sel_i ? rx_ready_i : irq_i;
      checks = checks + 1;
      test_checks = test_checks + 1;
      if (lvl_now !== exp_lvl_i) begin
        errors = errors + 1;
        test_errors = test_errors + 1;
        $display("Fail at %0t: %s expected %0b, got %0b", $time,
                 lvl_sel_i ? "rx_ready_o" : "irq_o", exp_lvl_i, lvl_now);
      end
    end
    if (test_end_i) begin
      tests = tests + 1;
      $display("Test %0d %s: %0d checks, %0d errors", test_num_i,
               (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (report_i) begin
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    end
  end

endmodule

`default_nettype wire

//--- hdl/rxq_top.sv
// Master must hold cyc, stb and address until ack; rx bytes move only while rx_ready_o is high
`timescale 1ns/1ps
`default_nettype none

module rxq_top import rxq_cfg_pkg::*; import rxq_reg_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_stb_i,
  input  wire logic              wb_we_i,
  input  wire logic [ADR_W-1:0]  wb_adr_i,
  input  wire logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0]      wb_dat_o,
  output logic                   wb_ack_o,
  input  wire logic              rx_valid_i,
  input  wire logic [7:0]        rx_data_i,
  input  wire logic              rx_last_i,
  output logic                   rx_ready_o,
  output logic                   irq_o
);

  qwr_if   wr_bus ();
  qthld_if thld_bus ();

  byte_packer byte_packer_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .rx_last_i  (rx_last_i),
    .rx_ready_o (rx_ready_o),
    .wr         (wr_bus.source)
  );

  read_queue read_queue_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wr     (wr_bus.target),
    .ctl    (thld_bus.queue)
  );

  rxq_csr_ctrl rxq_csr_ctrl_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o),
    .q        (thld_bus.ctrl)
  );

endmodule

`default_nettype wire

//--- hdl/rxq_csr_ctrl.sv
// Wishbone classic slave without sel; an aborted RX_DATA read still pops its word
`timescale 1ns/1ps
`default_nettype none

module rxq_csr_ctrl import rxq_cfg_pkg::*; import rxq_reg_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_stb_i,
  input  wire logic              wb_we_i,
  input  wire logic [ADR_W-1:0]  wb_adr_i,
  input  wire logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0]      wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   irq_o,
  qthld_if.ctrl                  q
);

  csr_state_e        state_q;
  rxq_reg_e          reg_sel;
  logic [THLD_W-1:0] start_thld_q, ready_thld_q;
  logic              ctrl_rst_q;
  logic [1:0]        irq_en_q;
  logic [DATA_W-1:0] rd_data;

  assign reg_sel      = rxq_reg_e'(wb_adr_i);
  assign q.start_thld = start_thld_q;
  assign q.ready_thld = ready_thld_q;
  assign q.reg_rst    = ctrl_rst_q;

  assign irq_o = (irq_en_q[IEN_START] & q.start_trig) | (irq_en_q[IEN_READY] & q.ready_trig);

  // Register read mux; RX_DATA here covers the empty case only
  always_comb begin
    rd_data = '0;
    case (reg_sel)
      THLD: begin
        rd_data[THLD_START_LSB +: THLD_W] = start_thld_q;
        rd_data[THLD_READY_LSB +: THLD_W] = q.ready_thld_eff;
      end
      STATUS: begin
        rd_data[ST_EMPTY] = q.empty;
        rd_data[ST_FULL]  = q.full;
        rd_data[ST_START] = q.start_trig;
        rd_data[ST_READY] = q.ready_trig;
      end
      CTRL:    rd_data[CTRL_QRST] = ctrl_rst_q;
      IRQ_EN:  rd_data[1:0] = irq_en_q;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      wb_ack_o     <= 1'b0;
      wb_dat_o     <= '0;
      q.req        <= 1'b0;
      start_thld_q <= '0;
      ready_thld_q <= '0;
      ctrl_rst_q   <= 1'b0;
      irq_en_q     <= '0;
    end else begin
      q.req    <= 1'b0;
      wb_ack_o <= 1'b0;
      // Queue reset bit drops once the queue reports empty
      if (q.reg_rst_we) begin
        ctrl_rst_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (wb_cyc_i && wb_stb_i) begin
            if (wb_we_i) begin
              case (reg_sel)
                THLD: begin
                  start_thld_q <= wb_dat_i[THLD_START_LSB +: THLD_W];
                  ready_thld_q <= wb_dat_i[THLD_READY_LSB +: THLD_W];
                end
                CTRL:    ctrl_rst_q <= wb_dat_i[CTRL_QRST];
                IRQ_EN:  irq_en_q <= wb_dat_i[1:0];
                default: ;
              endcase
              wb_ack_o <= 1'b1;
              state_q  <= DONE;
            end else if (reg_sel == RX_DATA && !q.empty) begin
              q.req   <= 1'b1;
              state_q <= POP_WAIT;
            end else begin
              wb_dat_o <= rd_data;
              wb_ack_o <= 1'b1;
              state_q  <= DONE;
            end
          end
        end
        POP_WAIT: begin
          if (q.ack) begin
            wb_dat_o <= q.rdata;
            wb_ack_o <= wb_cyc_i & wb_stb_i;
            state_q  <= DONE;
          end
        end
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> wb_cyc_i && wb_stb_i);

endmodule

`default_nettype wire

//--- hdl/byte_packer.sv
// Bytes fill a word little-endian; a last byte closes the word early with upper bytes zero
`timescale 1ns/1ps
`default_nettype none

module byte_packer import rxq_cfg_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       rx_valid_i,
  input  wire logic [7:0] rx_data_i,
  input  wire logic       rx_last_i,
  output logic            rx_ready_o,
  qwr_if.source           wr
);

  logic              rdy_q;
  logic [IDX_W-1:0]  idx_q;
  logic [DATA_W-1:0] acc_q;
  logic [DATA_W-1:0] word_next;
  logic              wvalid_q;
  logic [DATA_W-1:0] wdata_q;
  logic              take;
  logic              close;

  // Stall input while a finished word waits on a full queue
  assign rx_ready_o = rdy_q & ~(wvalid_q & wr.full);
  assign take  = rx_valid_i & rx_ready_o;
  assign close = take & (rx_last_i | (idx_q == IDX_W'(WORD_BYTES - 1)));

  always_comb begin
    word_next = acc_q;
    word_next[{idx_q, 3'b000} +: 8] = rx_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdy_q    <= 1'b0;
      idx_q    <= '0;
      acc_q    <= '0;
      wvalid_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
      if (wvalid_q && wr.wready) begin
        wvalid_q <= 1'b0;
      end
      if (close) begin
        wvalid_q <= 1'b1;
        acc_q    <= '0;
        idx_q    <= '0;
      end else if (take) begin
        acc_q <= word_next;
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (close) begin
      wdata_q <= word_next;
    end
  end

  assign wr.wvalid = wvalid_q;
  assign wr.wdata  = wdata_q;

  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr.wvalid && !wr.wready |=> wr.wvalid && $stable(wr.wdata));

endmodule

`default_nettype wire

//--- hdl/read_queue.sv
// Linear thresholds only; a ready threshold of QDEPTH or more is clamped to QDEPTH-1
`timescale 1ns/1ps
`default_nettype none

module read_queue import rxq_cfg_pkg::*; (
  input wire logic clk_i,
  input wire logic rst_ni,
  qwr_if.target    wr,
  qthld_if.queue   ctl
);

  logic [CNT_W-1:0]  fifo_depth;
  logic [CNT_W-1:0]  free_entries;
  logic              fifo_rvalid;
  logic [DATA_W-1:0] fifo_rdata;
  logic              pop_q;
  logic [THLD_W-1:0] ready_thld_q;

  sync_fifo #(
    .WIDTH(DATA_W),
    .DEPTH(QDEPTH)
  ) fifo_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (ctl.reg_rst),
    .wvalid_i (wr.wvalid),
    .wready_o (wr.wready),
    .wdata_i  (wr.wdata),
    .rvalid_o (fifo_rvalid),
    .rready_i (pop_q),
    .rdata_o  (fifo_rdata),
    .depth_o  (fifo_depth),
    .full_o   (wr.full)
  );

  assign ctl.full  = wr.full;
  assign ctl.empty = (fifo_depth == '0);
  assign free_entries = CNT_W'(QDEPTH) - fifo_depth;

  // Trigger levels
  assign ctl.start_trig = (|ctl.start_thld) && (free_entries >= CNT_W'(ctl.start_thld));
  assign ctl.ready_trig = (|ready_thld_q) && (fifo_depth >= CNT_W'(ready_thld_q));
  assign ctl.ready_thld_eff = ready_thld_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_thld_q   <= '0;
      ctl.reg_rst_we <= 1'b0;
    end else begin
      // Ready level must stay below the queue size
      ready_thld_q   <= (ctl.ready_thld >= THLD_W'(QDEPTH)) ? THLD_W'(QDEPTH - 1)
                                                             : ctl.ready_thld;
      ctl.reg_rst_we <= ctl.reg_rst & ctl.empty;
    end
  end

  // Pop handshake, held idle during a queue reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pop_q   <= 1'b0;
      ctl.ack <= 1'b0;
    end else if (ctl.reg_rst) begin
      pop_q   <= 1'b0;
      ctl.ack <= 1'b0;
    end else begin
      ctl.ack <= 1'b0;
      if (ctl.req) begin
        pop_q <= 1'b1;
      end
      if (pop_q && fifo_rvalid) begin
        pop_q   <= 1'b0;
        ctl.ack <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_q && fifo_rvalid) begin
      ctl.rdata <= fifo_rdata;
    end
  end

  // Request is issued only for a non-empty queue, so ack follows two edges later
  a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ctl.ack) |-> $past(ctl.req, 2));

endmodule

`default_nettype wire

//--- hdl/sync_fifo.sv
// No read bypass: rdata_o shows the head entry and is valid only while rvalid_o is high
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 16,
  localparam int unsigned CW = $clog2(DEPTH + 1)
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             clr_i,
  input  wire logic             wvalid_i,
  output logic                  wready_o,
  input  wire logic [WIDTH-1:0] wdata_i,
  output logic                  rvalid_o,
  input  wire logic             rready_i,
  output logic [WIDTH-1:0]      rdata_o,
  output logic [CW-1:0]         depth_o,
  output logic                  full_o
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wptr_q, rptr_q;
  logic [CW-1:0]    cnt_q;
  logic             push, pop;

  assign full_o   = (cnt_q == CW'(DEPTH));
  assign wready_o = ~full_o;
  assign rvalid_o = (cnt_q != '0);
  assign rdata_o  = mem[rptr_q];
  assign depth_o  = cnt_q;

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q <= CW'(DEPTH));

endmodule

`default_nettype wire

//--- hdl/rxq_if.sv
// Word transfer needs wvalid and wready high on one edge; full equals not wready
`timescale 1ns/1ps
`default_nettype none

interface qwr_if import rxq_cfg_pkg::*; ();
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic              full;

  modport source (output wvalid, output wdata, input wready, input full);
  modport target (input wvalid, input wdata, output wready, output full);
endinterface

interface qthld_if import rxq_cfg_pkg::*; ();
  // Driven by the register controller
  logic [THLD_W-1:0] start_thld;
  logic [THLD_W-1:0] ready_thld;
  logic              req;
  logic              reg_rst;
  // Driven by the queue
  logic [THLD_W-1:0] ready_thld_eff;
  logic              start_trig;
  logic              ready_trig;
  logic              empty;
  logic              full;
  logic              ack;
  logic [DATA_W-1:0] rdata;
  logic              reg_rst_we;

  modport ctrl (
    output start_thld, ready_thld, req, reg_rst,
    input  ready_thld_eff, start_trig, ready_trig, empty, full, ack, rdata, reg_rst_we
  );
  modport queue (
    input  start_thld, ready_thld, req, reg_rst,
    output ready_thld_eff, start_trig, ready_trig, empty, full, ack, rdata, reg_rst_we
  );
endinterface

`default_nettype wire

//--- hdl/rxq_reg_pkg.sv
// Register map uses word addresses on a 5-bit byte address; unmapped addresses read as zero
`default_nettype none

package rxq_reg_pkg;

  localparam int unsigned ADR_W = 5;

  typedef enum logic [ADR_W-1:0] {
    RX_DATA = 5'h00,
    THLD    = 5'h04,
    STATUS  = 5'h08,
    CTRL    = 5'h0C,
    IRQ_EN  = 5'h10
  } rxq_reg_e;

  // THLD field positions
  localparam int unsigned THLD_START_LSB = 0;
  localparam int unsigned THLD_READY_LSB = 8;

  // STATUS bits
  localparam int unsigned ST_EMPTY = 0;
  localparam int unsigned ST_FULL = 1;
  localparam int unsigned ST_START = 2;
  localparam int unsigned ST_READY = 3;

  // CTRL and IRQ_EN bits
  localparam int unsigned CTRL_QRST = 0;
  localparam int unsigned IEN_START = 0;
  localparam int unsigned IEN_READY = 1;

  typedef enum logic [1:0] {
    IDLE,
    POP_WAIT,
    DONE
  } csr_state_e;

endpackage

`default_nettype wire

//--- hdl/rxq_cfg_pkg.sv
// Queue geometry is fixed here; CNT_W must hold 0 to QDEPTH and THLD_W must hold QDEPTH
`default_nettype none

package rxq_cfg_pkg;

  // Read queue geometry
  localparam int unsigned QDEPTH = 16;
  localparam int unsigned DATA_W = 32;

  // Byte packing
  localparam int unsigned WORD_BYTES = DATA_W / 8;
  localparam int unsigned IDX_W = $clog2(WORD_BYTES);

  // Threshold field and fill count widths
  localparam int unsigned THLD_W = 5;
  localparam int unsigned CNT_W = $clog2(QDEPTH + 1);

endpackage

`default_nettype wire
